// File: logic/nabp_cfg_pkg.sv
`default_nettype none

package nabp_cfg_pkg;

    // default array geometry
    localparam int DEF_PE_WIDTH  = 8;
    localparam int DEF_ANGLE_LEN = 4;

    // datapath widths
    localparam int SAMPLE_W = 16;
    localparam int ACC_W    = 24;

    // one projection sample as fetched from memory
    typedef logic [SAMPLE_W-1:0] sample_t;

    // running pixel sum over all angles
    typedef logic [ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

// File: logic/nabp_ctrl_pkg.sv
`default_nettype none

package nabp_ctrl_pkg;

    // iteration cycle of one PE row
    typedef enum logic [2:0] {
        INIT,
        SETUP,
        FILL,
        FILL_DONE,
        SHIFT,
        SHIFT_DONE
    } iter_state_t;

endpackage

`default_nettype wire

// File: logic/nabp_iter_if.sv
`default_nettype none

// swap control <-> state control
interface nabp_swap_if #(
    parameter int ANGLE_LEN = 4,
    parameter int PE_WIDTH  = 8
);
    logic [ANGLE_LEN-1:0]         angle;
    logic [$clog2(PE_WIDTH)-1:0]  line_cnt;
    // another angle is waiting to be taken
    logic                         itr_valid;
    logic                         swap;
    logic                         swap_ready;
    logic                         next_itr;

    modport swapper (
        output angle, line_cnt, itr_valid, swap,
        input  swap_ready, next_itr
    );

    modport sequencer (
        input  angle, line_cnt, itr_valid, swap,
        output swap_ready, next_itr
    );
endinterface

// state control <-> shifter, single cycle pulses both ways
interface nabp_shift_if;
    logic fill_kick;
    logic shift_kick;
    logic fill_done;
    logic shift_done;

    modport sequencer (
        output fill_kick, shift_kick,
        input  fill_done, shift_done
    );

    modport shifter (
        input  fill_kick, shift_kick,
        output fill_done, shift_done
    );
endinterface

`default_nettype wire

// File: logic/nabp_state_control.sv
`default_nettype none

module nabp_state_control #(
    parameter int ANGLE_LEN = nabp_cfg_pkg::DEF_ANGLE_LEN,
    parameter int PE_WIDTH  = nabp_cfg_pkg::DEF_PE_WIDTH
) (
    input  wire                          clk,
    input  wire                          reset_n,
    nabp_swap_if.sequencer               sw,
    nabp_shift_if.sequencer              sh,
    output logic [ANGLE_LEN-1:0]         angle,
    output logic [$clog2(PE_WIDTH)-1:0]  line_cnt
);
    import nabp_ctrl_pkg::*;

    iter_state_t state;
    iter_state_t next_state;
    logic        fill_kick_r;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= INIT;
        else
            state <= next_state;
    end

    // iteration data held for the datapath
    always_ff @(posedge clk)
    begin
        if (state == SETUP)
        begin
            angle    <= sw.angle;
            line_cnt <= sw.line_cnt;
        end
    end

    // fill starts once the captured angle reaches the shifter
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            fill_kick_r <= 1'b0;
        else
            fill_kick_r <= (state == SETUP);
    end

    always_comb
    begin
        next_state = state;
        case (state)
            INIT, SHIFT_DONE:
                next_state = sw.itr_valid ? SETUP : INIT;
            SETUP:
                next_state = FILL;
            FILL:
                if (sh.fill_done)
                    next_state = FILL_DONE;
            FILL_DONE:
                if (sw.swap)
                    next_state = SHIFT;
            SHIFT:
                if (sh.shift_done)
                    next_state = SHIFT_DONE;
            default:
                next_state = INIT;
        endcase
    end

    assign sw.swap_ready = (state == FILL_DONE);
    assign sw.next_itr   = (state == INIT) || (state == SHIFT_DONE);

    assign sh.fill_kick  = fill_kick_r;
    // shift kick fires on entry only
    assign sh.shift_kick = (state != SHIFT) && (next_state == SHIFT);

endmodule

`default_nettype wire

// File: logic/nabp_swap_control.sv
`default_nettype none

module nabp_swap_control #(
    parameter int PE_WIDTH    = nabp_cfg_pkg::DEF_PE_WIDTH,
    parameter int ANGLE_LEN   = nabp_cfg_pkg::DEF_ANGLE_LEN,
    parameter int OFFSET_STEP = 1
) (
    input  wire          clk,
    input  wire          reset_n,
    input  wire          start,
    nabp_swap_if.swapper sw,
    output logic         done
);
    localparam int LW = $clog2(PE_WIDTH);
    localparam logic [LW:0] PE_W_EXT = (LW+1)'(PE_WIDTH);
    localparam logic [LW:0] STEP     = (LW+1)'(OFFSET_STEP % PE_WIDTH);
    localparam logic [ANGLE_LEN-1:0] LAST_ANGLE = '1;
    localparam logic [ANGLE_LEN-1:0] PRE_LAST   = LAST_ANGLE - 1'b1;

    logic                 running;
    // angle 0 is taken by the first next_itr, no advance there
    logic                 first;
    logic                 itr_valid_r;
    logic                 swap_r;
    logic [ANGLE_LEN-1:0] angle_r;
    logic [LW-1:0]        offset_r;
    logic [LW:0]          off_sum;

    // offset stepping by modular addition
    assign off_sum = {1'b0, offset_r} + STEP;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            running     <= 1'b0;
            first       <= 1'b0;
            itr_valid_r <= 1'b0;
            swap_r      <= 1'b0;
            done        <= 1'b0;
            angle_r     <= '0;
            offset_r    <= '0;
        end
        else
        begin
            done   <= 1'b0;
            swap_r <= sw.swap_ready && !swap_r;
            if (start)
            begin
                running     <= 1'b1;
                first       <= 1'b1;
                itr_valid_r <= 1'b1;
                angle_r     <= '0;
                offset_r    <= '0;
            end
            else if (running && sw.next_itr)
            begin
                if (first)
                    first <= 1'b0;
                else if (angle_r == LAST_ANGLE)
                begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
                else
                begin
                    angle_r  <= angle_r + 1'b1;
                    offset_r <= (off_sum >= PE_W_EXT) ? LW'(off_sum - PE_W_EXT)
                                                      : LW'(off_sum);
                    // last angle goes out now, nothing pending after it
                    if (angle_r == PRE_LAST)
                        itr_valid_r <= 1'b0;
                end
            end
        end
    end

    assign sw.angle     = angle_r;
    assign sw.line_cnt  = offset_r;
    assign sw.itr_valid = itr_valid_r;
    assign sw.swap      = swap_r;

endmodule

`default_nettype wire

// File: logic/nabp_shifter.sv
`default_nettype none

module nabp_shifter #(
    parameter int PE_WIDTH  = nabp_cfg_pkg::DEF_PE_WIDTH,
    parameter int ANGLE_LEN = nabp_cfg_pkg::DEF_ANGLE_LEN
) (
    input  wire                                    clk,
    input  wire                                    reset_n,
    nabp_shift_if.shifter                          sh,
    input  wire                                    swap,
    input  wire [ANGLE_LEN-1:0]                    angle,
    input  wire [$clog2(PE_WIDTH)-1:0]             line_cnt,
    output logic                                   wb_cyc,
    output logic                                   wb_stb,
    output logic [ANGLE_LEN+$clog2(PE_WIDTH)-1:0]  wb_adr,
    input  wire nabp_cfg_pkg::sample_t             wb_dat_i,
    input  wire                                    wb_ack,
    output nabp_cfg_pkg::sample_t                  taps [PE_WIDTH],
    output logic                                   acc_en
);
    import nabp_cfg_pkg::*;

    localparam int LW = $clog2(PE_WIDTH);
    localparam int AW = ANGLE_LEN + LW;
    localparam logic [LW-1:0] LAST_IDX = LW'(PE_WIDTH - 1);

    sample_t       fill_buf [PE_WIDTH];
    sample_t       rot [PE_WIDTH];
    logic          fetching;
    logic          fill_done_r;
    logic          shifting;
    logic [LW-1:0] fill_idx;
    logic [LW-1:0] shift_cnt;
    logic [AW-1:0] line_base;

    // first sample address of the current angle's line
    assign line_base = AW'(angle) * AW'(PE_WIDTH);

    // one classic read per sample, strobe dropped for a cycle after each ack
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fetching    <= 1'b0;
            fill_done_r <= 1'b0;
            fill_idx    <= '0;
            wb_cyc      <= 1'b0;
            wb_stb      <= 1'b0;
            wb_adr      <= '0;
        end
        else
        begin
            fill_done_r <= 1'b0;
            if (sh.fill_kick)
            begin
                fetching <= 1'b1;
                fill_idx <= '0;
                wb_adr   <= line_base;
                wb_cyc   <= 1'b1;
                wb_stb   <= 1'b1;
            end
            else if (wb_stb)
            begin
                if (wb_ack)
                begin
                    wb_cyc <= 1'b0;
                    wb_stb <= 1'b0;
                    if (fill_idx == LAST_IDX)
                    begin
                        fetching    <= 1'b0;
                        fill_done_r <= 1'b1;
                    end
                    else
                    begin
                        fill_idx <= fill_idx + 1'b1;
                        wb_adr   <= wb_adr + 1'b1;
                    end
                end
            end
            else if (fetching)
            begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wb_stb && wb_ack)
            fill_buf[fill_idx] <= wb_dat_i;
    end

    // rotation step count, then one accumulate cycle at zero
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            shifting  <= 1'b0;
            shift_cnt <= '0;
        end
        else if (sh.shift_kick)
        begin
            shifting  <= 1'b1;
            shift_cnt <= line_cnt;
        end
        else if (shifting)
        begin
            if (shift_cnt != '0)
                shift_cnt <= shift_cnt - 1'b1;
            else
                shifting <= 1'b0;
        end
    end

    // tap i takes element i+1 on every step
    always_ff @(posedge clk)
    begin
        if (swap)
            rot <= fill_buf;
        else if (shifting && shift_cnt != '0)
        begin
            for (int i = 0; i < PE_WIDTH; i++)
                rot[i] <= rot[(i + 1) % PE_WIDTH];
        end
    end

    assign taps          = rot;
    assign acc_en        = shifting && (shift_cnt == '0);
    assign sh.shift_done = acc_en;
    assign sh.fill_done  = fill_done_r;

endmodule

`default_nettype wire

// File: logic/nabp_pe_array.sv
`default_nettype none

module nabp_pe_array #(
    parameter int PE_WIDTH = nabp_cfg_pkg::DEF_PE_WIDTH
) (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         start,
    input  wire                         acc_en,
    input  wire nabp_cfg_pkg::sample_t  taps [PE_WIDTH],
    input  wire [$clog2(PE_WIDTH)-1:0]  rd_addr,
    output nabp_cfg_pkg::acc_t          rd_data
);
    import nabp_cfg_pkg::*;

    acc_t acc [PE_WIDTH];

    // one accumulator per PE, cleared again by each start
    always_ff @(posedge clk)
    begin
        if (!reset_n || start)
        begin
            for (int i = 0; i < PE_WIDTH; i++)
                acc[i] <= '0;
        end
        else if (acc_en)
        begin
            for (int i = 0; i < PE_WIDTH; i++)
                acc[i] <= acc[i] + ACC_W'(taps[i]);
        end
    end

    // readout mux
    assign rd_data = acc[rd_addr];

endmodule

`default_nettype wire

// File: logic/nabp_top.sv
`default_nettype none

module nabp_top #(
    parameter int PE_WIDTH    = nabp_cfg_pkg::DEF_PE_WIDTH,
    parameter int ANGLE_LEN   = nabp_cfg_pkg::DEF_ANGLE_LEN,
    parameter int OFFSET_STEP = 3
) (
    input  wire                                   clk,
    input  wire                                   reset_n,
    input  wire                                   start,
    output wire                                   wb_cyc,
    output wire                                   wb_stb,
    output wire                                   wb_we,
    output wire [ANGLE_LEN+$clog2(PE_WIDTH)-1:0]  wb_adr,
    input  wire nabp_cfg_pkg::sample_t            wb_dat_i,
    input  wire                                   wb_ack,
    output wire                                   done,
    input  wire [$clog2(PE_WIDTH)-1:0]            rd_addr,
    output wire nabp_cfg_pkg::acc_t               rd_data
);
    import nabp_cfg_pkg::*;

    localparam int LW = $clog2(PE_WIDTH);

    logic [ANGLE_LEN-1:0] angle;
    logic [LW-1:0]        line_cnt;
    sample_t              taps [PE_WIDTH];
    logic                 acc_en;

    nabp_swap_if #(.ANGLE_LEN(ANGLE_LEN), .PE_WIDTH(PE_WIDTH)) swap_bus ();
    nabp_shift_if shift_bus ();

    // read-only master
    assign wb_we = 1'b0;

    nabp_swap_control #(
        .PE_WIDTH(PE_WIDTH), .ANGLE_LEN(ANGLE_LEN), .OFFSET_STEP(OFFSET_STEP)
    ) u_swap_control (
        .clk(clk), .reset_n(reset_n), .start(start), .sw(swap_bus), .done(done)
    );

    nabp_state_control #(.ANGLE_LEN(ANGLE_LEN), .PE_WIDTH(PE_WIDTH)) u_state_control (
        .clk(clk), .reset_n(reset_n), .sw(swap_bus), .sh(shift_bus),
        .angle(angle), .line_cnt(line_cnt)
    );

    nabp_shifter #(.PE_WIDTH(PE_WIDTH), .ANGLE_LEN(ANGLE_LEN)) u_shifter (
        .clk(clk), .reset_n(reset_n), .sh(shift_bus), .swap(swap_bus.swap),
        .angle(angle), .line_cnt(line_cnt),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .taps(taps), .acc_en(acc_en)
    );

    nabp_pe_array #(.PE_WIDTH(PE_WIDTH)) u_pe_array (
        .clk(clk), .reset_n(reset_n), .start(start), .acc_en(acc_en),
        .taps(taps), .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// File: verif/nabp_properties.sv
`default_nettype none

module nabp_properties #(
    parameter int ADR_W = 6,
    parameter int LW    = 3
) (
    input wire             clk,
    input wire             reset_n,
    input wire             wb_cyc,
    input wire             wb_stb,
    input wire             wb_we,
    input wire [ADR_W-1:0] wb_adr,
    input wire             wb_ack,
    input wire             fill_kick,
    input wire             fill_done,
    input wire             shift_kick,
    input wire             shift_done,
    input wire [LW-1:0]    line_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    // failed assertions so far, polled from the testbench top
    int unsigned violations;
    logic        fill_open;
    // cycles left until shift_done is due
    int unsigned shift_wait;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_open  <= 1'b0;
            shift_wait <= 0;
        end
        else
        begin
            if (fill_kick)
                fill_open <= 1'b1;
            else if (fill_done)
                fill_open <= 1'b0;
            if (shift_kick)
                shift_wait <= int'(line_cnt) + 1;
            else if (shift_wait != 0)
                shift_wait <= shift_wait - 1;
        end
    end

    // request held until the slave answers
    stb_held: assert property (@(posedge clk) disable iff (!reset_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
    else
    begin
        violations++;
        $error("wb_stb dropped or wb_adr moved before wb_ack");
    end

    stb_drops: assert property (@(posedge clk) disable iff (!reset_n)
        wb_stb && wb_ack |=> !wb_stb)
    else
    begin
        violations++;
        $error("wb_stb still high in the cycle after wb_ack");
    end

    read_only: assert property (@(posedge clk) disable iff (!reset_n) !wb_we)
    else
    begin
        violations++;
        $error("wb_we set on a read-only master");
    end

    fill_kick_idle: assert property (@(posedge clk) disable iff (!reset_n)
        fill_kick |-> !fill_open && shift_wait == 0)
    else
    begin
        violations++;
        $error("fill_kick while a fill or shift is still open");
    end

    fill_done_owned: assert property (@(posedge clk) disable iff (!reset_n)
        fill_done |-> fill_open)
    else
    begin
        violations++;
        $error("fill_done without a preceding fill_kick");
    end

    shift_kick_idle: assert property (@(posedge clk) disable iff (!reset_n)
        shift_kick |-> !fill_open && shift_wait == 0)
    else
    begin
        violations++;
        $error("shift_kick while a fill or shift is still open");
    end

    // done exactly line_cnt+1 cycles after the kick
    shift_done_timing: assert property (@(posedge clk) disable iff (!reset_n)
        shift_done == (shift_wait == 1))
    else
    begin
        violations++;
        $error("shift_done not line_cnt+1 cycles after shift_kick");
    end

endmodule

bind nabp_top nabp_properties #(
    .ADR_W(ANGLE_LEN + $clog2(PE_WIDTH)),
    .LW($clog2(PE_WIDTH))
) handshake_checks (
    .clk(clk), .reset_n(reset_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_ack(wb_ack),
    .fill_kick(shift_bus.fill_kick), .fill_done(shift_bus.fill_done),
    .shift_kick(shift_bus.shift_kick), .shift_done(shift_bus.shift_done),
    .line_cnt(line_cnt)
);

`default_nettype wire

// File: verif/nabp_tb.sv
`default_nettype none

module nabp_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import nabp_cfg_pkg::*;

    localparam int PE_WIDTH     = 8;
    localparam int ANGLE_LEN    = 3;
    localparam int OFFSET_STEP  = 3;
    localparam int ANGLES       = 1 << ANGLE_LEN;
    localparam int RD_W         = $clog2(PE_WIDTH);
    localparam int ADR_W        = ANGLE_LEN + RD_W;
    localparam int STB_TIMEOUT  = 200;
    localparam int DONE_TIMEOUT = 200;

    logic             clk;
    logic             reset_n;
    logic             start;
    wire              wb_cyc;
    wire              wb_stb;
    wire              wb_we;
    wire [ADR_W-1:0]  wb_adr;
    sample_t          wb_dat_i;
    logic             wb_ack;
    wire              done;
    logic [RD_W-1:0]  rd_addr;
    acc_t             rd_data;
    logic [31:0]      rng_state;

    nabp_top #(
        .PE_WIDTH(PE_WIDTH), .ANGLE_LEN(ANGLE_LEN), .OFFSET_STEP(OFFSET_STEP)
    ) UUT (
        .clk(clk), .reset_n(reset_n), .start(start),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .done(done), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // memory contents: low 16 bits of adr*37+5
    function automatic sample_t sample_at(input int adr);
        return sample_t'(adr * 37 + 5);
    endfunction

    // pixel i sums sample (i + 3a) mod 8 of every line a
    function automatic acc_t reference_pixel(input int pix);
        acc_t sum;
        int   off;
        sum = '0;
        for (int a = 0; a < ANGLES; a++)
        begin
            off = (a * OFFSET_STEP) % PE_WIDTH;
            sum = sum + acc_t'(sample_at(a * PE_WIDTH + (pix + off) % PE_WIDTH));
        end
        return sum;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        abort_run($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act));
    endtask

    // one slave read with 0 to 3 random wait cycles
    task automatic serve_read(input int exp_adr);
        int              waited;
        int              delay;
        logic [ADR_W-1:0] adr;
        waited = 0;
        @(negedge clk);
        while (wb_stb !== 1'b1)
        begin
            if (waited == STB_TIMEOUT)
                abort_run($sformatf("timeout waiting for a Wishbone read of address %0d", exp_adr));
            waited++;
            @(negedge clk);
        end
        adr = wb_adr;
        assert (adr == ADR_W'(exp_adr))
        else
            value_mismatch("wb_adr", exp_adr, adr);
        rng_state = xorshift32(rng_state);
        delay = int'(rng_state % 4);
        repeat (delay) @(posedge clk);
        @(posedge clk);
        wb_ack   <= 1'b1;
        wb_dat_i <= sample_at(int'(adr));
        @(posedge clk);
        wb_ack <= 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (done !== 1'b1)
        begin
            if (waited == DONE_TIMEOUT)
                abort_run("timeout waiting for done after the last angle");
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic check_readout(input logic cleared);
        acc_t want;
        for (int i = 0; i < PE_WIDTH; i++)
        begin
            @(posedge clk);
            rd_addr <= RD_W'(i);
            @(negedge clk);
            want = cleared ? acc_t'(0) : reference_pixel(i);
            assert (rd_data == want)
            else
                value_mismatch("rd_data", want, rd_data);
        end
    endtask

    task automatic run_pass();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (int a = 0; a < ANGLES; a++)
        begin
            for (int s = 0; s < PE_WIDTH; s++)
                serve_read(a * PE_WIDTH + s);
        end
        wait_done();
        check_readout(1'b0);
    endtask

    // bound handshake assertions feed this watcher
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (UUT.handshake_checks.violations != 0)
                abort_run("a Wishbone or kick/done handshake assertion failed");
        end
    end

    initial
    begin
        reset_n   = 1'b0;
        start     = 1'b0;
        wb_ack    = 1'b0;
        wb_dat_i  = '0;
        rd_addr   = '0;
        rng_state = 32'd55197;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        @(negedge clk);
        assert (wb_cyc == 1'b0) else value_mismatch("wb_cyc", 0, wb_cyc);
        assert (wb_stb == 1'b0) else value_mismatch("wb_stb", 0, wb_stb);
        assert (done == 1'b0) else value_mismatch("done", 0, done);
        check_readout(1'b1);

        // second start reuses the row without a reset
        run_pass();
        run_pass();

        @(negedge clk);
        if (UUT.handshake_checks.violations != 0)
            abort_run("a Wishbone or kick/done handshake assertion failed");
        else
        begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: nabp_top.f
logic/nabp_cfg_pkg.sv
logic/nabp_ctrl_pkg.sv
logic/nabp_iter_if.sv
logic/nabp_state_control.sv
logic/nabp_swap_control.sv
logic/nabp_shifter.sv
logic/nabp_pe_array.sv
logic/nabp_top.sv
verif/nabp_properties.sv
verif/nabp_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run nabp_tb with Verilator, pass only if the log holds the pass line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module nabp_tb \
    -f nabp_top.f -o nabp_sim &&
    ./obj_dir/nabp_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log 2>/dev/null && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
